// ==== hw/lsu_pkg.sv ====
package lsu_pkg;

    localparam int data_w = 32;
    // word address bits of the 1 KiB data RAM
    localparam int ram_aw = 8;
    localparam int reg_aw = 5;

    typedef enum logic [3:0] {
        op_none = 4'd0,
        op_lw   = 4'd1,
        op_lh   = 4'd2,
        op_lhu  = 4'd3,
        op_lb   = 4'd4,
        op_lbu  = 4'd5,
        op_lwl  = 4'd6,
        op_lwr  = 4'd7,
        op_sw   = 4'd8,
        op_sh   = 4'd9,
        op_sb   = 4'd10
    } mem_op_e;

    // MIPS address error codes
    typedef enum logic [4:0] {
        exc_adel = 5'd4,
        exc_ades = 5'd5
    } excode_e;

endpackage

// ==== hw/lsu_stage_if.sv ====
`timescale 1ns/1ps

interface lsu_stage_if;

    logic                          valid;
    logic                          allowin;
    lsu_pkg::mem_op_e              op;
    logic [lsu_pkg::data_w-1:0]    addr;
    logic [lsu_pkg::data_w-1:0]    rt_value;
    logic [lsu_pkg::reg_aw-1:0]    dest;
    logic                          ex;
    lsu_pkg::excode_e              excode;
    // only meaningful from the align stage on
    logic [lsu_pkg::data_w-1:0]    result;

    modport src (
        output valid, op, addr, rt_value, dest, ex, excode, result,
        input  allowin
    );

    modport dst (
        input  valid, op, addr, rt_value, dest, ex, excode, result,
        output allowin
    );

endinterface

// ==== hw/data_ram.sv ====
`timescale 1ns/1ps

module data_ram (
    input  logic                          clk,
    input  logic                          en,
    input  logic [3:0]                    we,
    input  logic [lsu_pkg::ram_aw-1:0]    addr,
    input  logic [lsu_pkg::data_w-1:0]    wdata,
    output logic [lsu_pkg::data_w-1:0]    rdata
);

    logic [lsu_pkg::data_w-1:0] mem [1 << lsu_pkg::ram_aw];

    always_ff @(posedge clk) begin
        if (en) begin
            for (int i = 0; i < 4; i++) begin
                if (we[i]) begin
                    mem[addr][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
            // read returns the old word on a write
            rdata <= mem[addr];
        end
    end

endmodule

// ==== hw/mem_issue.sv ====
`timescale 1ns/1ps

module mem_issue (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          in_valid,
    input  lsu_pkg::mem_op_e              in_op,
    input  logic [lsu_pkg::data_w-1:0]    in_addr,
    input  logic [lsu_pkg::data_w-1:0]    in_store_data,
    input  logic [lsu_pkg::data_w-1:0]    in_rt_value,
    input  logic [lsu_pkg::reg_aw-1:0]    in_dest,
    output logic                          in_allowin,
    input  logic                          flush,
    input  logic                          exc_below,
    output logic                          ram_en,
    output logic [3:0]                    ram_we,
    output logic [lsu_pkg::ram_aw-1:0]    ram_addr,
    output logic [lsu_pkg::data_w-1:0]    ram_wdata,
    lsu_stage_if.src                      down
);

    logic                         valid;
    lsu_pkg::mem_op_e             r_op;
    logic [lsu_pkg::data_w-1:0]   r_addr;
    logic [lsu_pkg::data_w-1:0]   r_store_data;
    logic [lsu_pkg::data_w-1:0]   r_rt_value;
    logic [lsu_pkg::reg_aw-1:0]   r_dest;
    logic                         ex;
    lsu_pkg::excode_e             excode;
    logic [3:0]                   byte_en;
    logic                         to_down;

    assign in_allowin = !valid || down.allowin;
    assign to_down    = valid && down.allowin;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid <= 1'b0;
        end else if (flush) begin
            valid <= 1'b0;
        end else if (in_allowin) begin
            valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_allowin) begin
            r_op         <= in_op;
            r_addr       <= in_addr;
            r_store_data <= in_store_data;
            r_rt_value   <= in_rt_value;
            r_dest       <= in_dest;
        end
    end

    // alignment check and store lane enables
    always_comb begin
        ex      = 1'b0;
        excode  = lsu_pkg::exc_adel;
        byte_en = 4'b0000;
        case (r_op)
            lsu_pkg::op_lw:  ex = (r_addr[1:0] != 2'b00);
            lsu_pkg::op_lh,
            lsu_pkg::op_lhu: ex = r_addr[0];
            lsu_pkg::op_sw: begin
                ex      = (r_addr[1:0] != 2'b00);
                excode  = lsu_pkg::exc_ades;
                byte_en = 4'b1111;
            end
            lsu_pkg::op_sh: begin
                ex      = r_addr[0];
                excode  = lsu_pkg::exc_ades;
                byte_en = r_addr[1] ? 4'b1100 : 4'b0011;
            end
            lsu_pkg::op_sb:  byte_en = 4'b0001 << r_addr[1:0];
            default: ;
        endcase
    end

    // request only for the instruction actually leaving, never under a fault
    assign ram_en   = to_down && !ex && !exc_below && (r_op != lsu_pkg::op_none);
    assign ram_we   = ram_en ? byte_en : 4'b0000;
    assign ram_addr = r_addr[lsu_pkg::ram_aw+1:2];

    always_comb begin
        case (r_op)
            lsu_pkg::op_sh: ram_wdata = {16'h0000, r_store_data[15:0]} << {r_addr[1:0], 3'b000};
            lsu_pkg::op_sb: ram_wdata = {24'h000000, r_store_data[7:0]} << {r_addr[1:0], 3'b000};
            default:        ram_wdata = r_store_data;
        endcase
    end

    assign down.valid    = valid;
    assign down.op       = r_op;
    assign down.addr     = r_addr;
    assign down.rt_value = r_rt_value;
    assign down.dest     = r_dest;
    assign down.ex       = ex;
    assign down.excode   = excode;
    // address value is the pass-through result
    assign down.result   = r_addr;

endmodule

// ==== hw/mem_align.sv ====
`timescale 1ns/1ps

module mem_align (
    input  logic                          clk,
    input  logic                          arst_n,
    lsu_stage_if.dst                      up,
    lsu_stage_if.src                      down,
    input  logic [lsu_pkg::data_w-1:0]    ram_rdata,
    input  logic                          flush,
    output logic                          exc_here
);

    logic                         valid;
    lsu_pkg::mem_op_e             r_op;
    logic [lsu_pkg::data_w-1:0]   r_addr;
    logic [lsu_pkg::data_w-1:0]   r_rt_value;
    logic [lsu_pkg::reg_aw-1:0]   r_dest;
    logic                         r_ex;
    lsu_pkg::excode_e             r_excode;
    logic [lsu_pkg::data_w-1:0]   r_result;
    logic                         rdata_fresh;
    logic [lsu_pkg::data_w-1:0]   held_rdata;
    logic [lsu_pkg::data_w-1:0]   word;
    logic [1:0]                   lane;
    logic [7:0]                   byte_sel;
    logic [15:0]                  half_sel;
    logic [lsu_pkg::data_w-1:0]   result;

    assign up.allowin = !valid || down.allowin;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid       <= 1'b0;
            rdata_fresh <= 1'b0;
        end else begin
            // RAM word shows up the cycle after the transfer in
            rdata_fresh <= up.valid && up.allowin && !flush;
            if (flush) begin
                valid <= 1'b0;
            end else if (up.allowin) begin
                valid <= up.valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (up.valid && up.allowin) begin
            r_op       <= up.op;
            r_addr     <= up.addr;
            r_rt_value <= up.rt_value;
            r_dest     <= up.dest;
            r_ex       <= up.ex;
            r_excode   <= up.excode;
            r_result   <= up.result;
        end
        // keep the read word across a stall
        if (rdata_fresh) begin
            held_rdata <= ram_rdata;
        end
    end

    assign word     = rdata_fresh ? ram_rdata : held_rdata;
    assign lane     = r_addr[1:0];
    assign byte_sel = 8'(word >> {lane, 3'b000});
    assign half_sel = lane[1] ? word[31:16] : word[15:0];

    always_comb begin
        case (r_op)
            lsu_pkg::op_lw:  result = word;
            lsu_pkg::op_lh:  result = {{16{half_sel[15]}}, half_sel};
            lsu_pkg::op_lhu: result = {16'h0000, half_sel};
            lsu_pkg::op_lb:  result = {{24{byte_sel[7]}}, byte_sel};
            lsu_pkg::op_lbu: result = {24'h000000, byte_sel};
            // low memory bytes go to the top of rt
            lsu_pkg::op_lwl: result = (word << {~lane, 3'b000})
                                    | (r_rt_value & ~(32'hffff_ffff << {~lane, 3'b000}));
            // high memory bytes go to the bottom of rt
            lsu_pkg::op_lwr: result = (word >> {lane, 3'b000})
                                    | (r_rt_value & ~(32'hffff_ffff >> {lane, 3'b000}));
            default:         result = r_result;
        endcase
        // faulting access carries its address as badvaddr
        if (r_ex) begin
            result = r_addr;
        end
    end

    assign exc_here      = valid && r_ex;

    assign down.valid    = valid;
    assign down.op       = r_op;
    assign down.addr     = r_addr;
    assign down.rt_value = r_rt_value;
    assign down.dest     = r_dest;
    assign down.ex       = r_ex;
    assign down.excode   = r_excode;
    assign down.result   = result;

endmodule

// ==== hw/wb_commit.sv ====
`timescale 1ns/1ps

module wb_commit (
    input  logic                          clk,
    input  logic                          arst_n,
    lsu_stage_if.dst                      up,
    input  logic                          res_allowin,
    output logic                          res_valid,
    output logic                          res_we,
    output logic [lsu_pkg::reg_aw-1:0]    res_dest,
    output logic [lsu_pkg::data_w-1:0]    res_data,
    output logic                          exc_valid,
    output lsu_pkg::excode_e              exc_code,
    output logic [lsu_pkg::data_w-1:0]    exc_badvaddr,
    output logic                          flush,
    output logic                          exc_here
);

    logic                         valid;
    lsu_pkg::mem_op_e             r_op;
    logic [lsu_pkg::reg_aw-1:0]   r_dest;
    logic                         r_ex;
    lsu_pkg::excode_e             r_excode;
    logic [lsu_pkg::data_w-1:0]   r_result;

    assign up.allowin = !valid || res_allowin;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid <= 1'b0;
        end else if (flush) begin
            valid <= 1'b0;
        end else if (up.allowin) begin
            valid <= up.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (up.valid && up.allowin) begin
            r_op     <= up.op;
            r_dest   <= up.dest;
            r_ex     <= up.ex;
            r_excode <= up.excode;
            r_result <= up.result;
        end
    end

    assign exc_here = valid && r_ex;
    // fault retires this cycle, so drop everything younger
    assign flush    = exc_here && res_allowin;

    assign res_valid    = valid && !r_ex;
    assign res_we       = !(r_op inside {lsu_pkg::op_sw, lsu_pkg::op_sh, lsu_pkg::op_sb});
    assign res_dest     = r_dest;
    assign res_data     = r_result;

    assign exc_valid    = exc_here;
    assign exc_code     = r_excode;
    assign exc_badvaddr = r_result;

endmodule

// ==== hw/lsu_top.sv ====
`timescale 1ns/1ps

module lsu_top (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          in_valid,
    input  lsu_pkg::mem_op_e              in_op,
    input  logic [lsu_pkg::data_w-1:0]    in_addr,
    input  logic [lsu_pkg::data_w-1:0]    in_store_data,
    input  logic [lsu_pkg::data_w-1:0]    in_rt_value,
    input  logic [lsu_pkg::reg_aw-1:0]    in_dest,
    output logic                          in_allowin,
    input  logic                          res_allowin,
    output logic                          res_valid,
    output logic                          res_we,
    output logic [lsu_pkg::reg_aw-1:0]    res_dest,
    output logic [lsu_pkg::data_w-1:0]    res_data,
    output logic                          exc_valid,
    output lsu_pkg::excode_e              exc_code,
    output logic [lsu_pkg::data_w-1:0]    exc_badvaddr
);

    logic                         ram_en;
    logic [3:0]                   ram_we;
    logic [lsu_pkg::ram_aw-1:0]   ram_addr;
    logic [lsu_pkg::data_w-1:0]   ram_wdata;
    logic [lsu_pkg::data_w-1:0]   ram_rdata;
    logic                         flush;
    logic                         exc_align;
    logic                         exc_commit;
    logic                         exc_below;

    lsu_stage_if issue_to_align ();
    lsu_stage_if align_to_commit ();

    // any older fault blocks stores in the issue stage
    assign exc_below = exc_align || exc_commit;

    mem_issue u_mem_issue (
        .clk           (clk),
        .arst_n        (arst_n),
        .in_valid      (in_valid),
        .in_op         (in_op),
        .in_addr       (in_addr),
        .in_store_data (in_store_data),
        .in_rt_value   (in_rt_value),
        .in_dest       (in_dest),
        .in_allowin    (in_allowin),
        .flush         (flush),
        .exc_below     (exc_below),
        .ram_en        (ram_en),
        .ram_we        (ram_we),
        .ram_addr      (ram_addr),
        .ram_wdata     (ram_wdata),
        .down          (issue_to_align)
    );

    mem_align u_mem_align (
        .clk       (clk),
        .arst_n    (arst_n),
        .up        (issue_to_align),
        .down      (align_to_commit),
        .ram_rdata (ram_rdata),
        .flush     (flush),
        .exc_here  (exc_align)
    );

    wb_commit u_wb_commit (
        .clk          (clk),
        .arst_n       (arst_n),
        .up           (align_to_commit),
        .res_allowin  (res_allowin),
        .res_valid    (res_valid),
        .res_we       (res_we),
        .res_dest     (res_dest),
        .res_data     (res_data),
        .exc_valid    (exc_valid),
        .exc_code     (exc_code),
        .exc_badvaddr (exc_badvaddr),
        .flush        (flush),
        .exc_here     (exc_commit)
    );

    data_ram u_data_ram (
        .clk   (clk),
        .en    (ram_en),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

endmodule

// ==== dv/lsu_properties.sv ====
`timescale 1ns/1ps

module lsu_properties (
    input logic                          clk,
    input logic                          arst_n,
    input logic                          res_valid,
    input logic                          res_allowin,
    input logic                          res_we,
    input logic [lsu_pkg::reg_aw-1:0]    res_dest,
    input logic [lsu_pkg::data_w-1:0]    res_data,
    input logic                          flush,
    input logic                          issue_valid,
    input logic                          align_valid,
    input logic                          commit_valid,
    input logic                          exc_below,
    input logic [3:0]                    ram_we
);

    // stalled result holds until taken
    result_held: assert property (
        @(posedge clk) disable iff (!arst_n)
        res_valid && !res_allowin |=> res_valid && $stable(res_we)
            && $stable(res_dest) && $stable(res_data)
    ) else $error("result changed while res_allowin was low");

    flush_empties: assert property (
        @(posedge clk) disable iff (!arst_n)
        flush |=> !issue_valid && !align_valid && !commit_valid
    ) else $error("a stage stayed valid after flush");

    no_write_under_fault: assert property (
        @(posedge clk) disable iff (!arst_n)
        exc_below |-> ram_we == 4'b0000
    ) else $error("RAM write requested behind a faulting instruction");

endmodule

bind lsu_top lsu_properties u_lsu_properties (
    .clk          (clk),
    .arst_n       (arst_n),
    .res_valid    (res_valid),
    .res_allowin  (res_allowin),
    .res_we       (res_we),
    .res_dest     (res_dest),
    .res_data     (res_data),
    .flush        (flush),
    .issue_valid  (issue_to_align.valid),
    .align_valid  (align_to_commit.valid),
    .commit_valid (res_valid || exc_valid),
    // older fault seen on the stage links themselves
    .exc_below    ((align_to_commit.valid && align_to_commit.ex) || exc_valid),
    .ram_we       (ram_we)
);

// ==== dv/lsu_tb.sv ====
`timescale 1ns/1ps

module lsu_tb;

    logic                          clk;
    logic                          arst_n;
    logic                          in_valid;
    lsu_pkg::mem_op_e              in_op;
    logic [lsu_pkg::data_w-1:0]    in_addr;
    logic [lsu_pkg::data_w-1:0]    in_store_data;
    logic [lsu_pkg::data_w-1:0]    in_rt_value;
    logic [lsu_pkg::reg_aw-1:0]    in_dest;
    logic                          in_allowin;
    logic                          res_allowin;
    logic                          res_valid;
    logic                          res_we;
    logic [lsu_pkg::reg_aw-1:0]    res_dest;
    logic [lsu_pkg::data_w-1:0]    res_data;
    logic                          exc_valid;
    lsu_pkg::excode_e              exc_code;
    logic [lsu_pkg::data_w-1:0]    exc_badvaddr;

    // trace entries in offer order
    lsu_pkg::mem_op_e              tr_op[$];
    logic [lsu_pkg::data_w-1:0]    tr_addr[$];
    logic [lsu_pkg::data_w-1:0]    tr_wdata[$];
    logic [lsu_pkg::data_w-1:0]    tr_rt[$];
    logic [lsu_pkg::reg_aw-1:0]    tr_dest[$];
    // expected responses without the discarded entries
    logic [3:0]                    exp_kind[$];
    logic [lsu_pkg::reg_aw-1:0]    exp_dest[$];
    logic [lsu_pkg::data_w-1:0]    exp_val[$];
    string                         exp_name[$];
    int                            checks;
    int                            fails;

    lsu_top UUT (
        .clk           (clk),
        .arst_n        (arst_n),
        .in_valid      (in_valid),
        .in_op         (in_op),
        .in_addr       (in_addr),
        .in_store_data (in_store_data),
        .in_rt_value   (in_rt_value),
        .in_dest       (in_dest),
        .in_allowin    (in_allowin),
        .res_allowin   (res_allowin),
        .res_valid     (res_valid),
        .res_we        (res_we),
        .res_dest      (res_dest),
        .res_data      (res_data),
        .exc_valid     (exc_valid),
        .exc_code      (exc_code),
        .exc_badvaddr  (exc_badvaddr)
    );

    always #20 clk = ~clk;

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic load_trace();
        int          fd;
        int          n;
        int          lineno;
        string       line;
        logic [31:0] f_op;
        logic [31:0] f_addr;
        logic [31:0] f_wdata;
        logic [31:0] f_rt;
        logic [31:0] f_dest;
        logic [31:0] f_kind;
        logic [31:0] f_exp;
        lsu_pkg::mem_op_e op;
        fd = $fopen("dv/lsu_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open the trace file dv/lsu_trace.txt");
            fails++;
            return;
        end
        lineno = 0;
        while ($fgets(line, fd) > 0) begin
            lineno++;
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h",
                        f_op, f_addr, f_wdata, f_rt, f_dest, f_kind, f_exp);
            if (n != 7) begin
                $display("trace line %0d is malformed", lineno);
                fails++;
                continue;
            end
            op = lsu_pkg::mem_op_e'(f_op[3:0]);
            tr_op.push_back(op);
            tr_addr.push_back(f_addr);
            tr_wdata.push_back(f_wdata);
            tr_rt.push_back(f_rt);
            tr_dest.push_back(f_dest[4:0]);
            if (f_kind[3:0] != 4'hf) begin
                exp_kind.push_back(f_kind[3:0]);
                exp_dest.push_back(f_dest[4:0]);
                exp_val.push_back(f_exp);
                exp_name.push_back($sformatf("line %0d %s %h", lineno, op.name(), f_addr));
            end
        end
        $fclose(fd);
    endtask

    task automatic drive_trace();
        int waited;
        for (int i = 0; i < tr_op.size(); i++) begin
            in_valid      = 1'b1;
            in_op         = tr_op[i];
            in_addr       = tr_addr[i];
            in_store_data = tr_wdata[i];
            in_rt_value   = tr_rt[i];
            in_dest       = tr_dest[i];
            waited        = 0;
            @(negedge clk);
            while (!in_allowin && waited < 200) begin
                waited++;
                @(negedge clk);
            end
            if (!in_allowin) begin
                $display("in_allowin stayed low for 200 cycles at trace entry %0d", i);
                fails++;
                break;
            end
            @(posedge clk);
            #2;
        end
        in_valid = 1'b0;
    endtask

    task automatic check_result(input string name, input logic exp_we,
                                input logic [lsu_pkg::reg_aw-1:0] exp_dest_v,
                                input logic [lsu_pkg::data_w-1:0] exp_data);
        checks++;
        if (!res_valid) begin
            $display("%s raised an exception where a result was expected", name);
            fails++;
        end else if (res_we !== exp_we || res_dest !== exp_dest_v || res_data !== exp_data) begin
            $display("MISMATCH %s expected we=%b dest=%0d data=%h actual we=%b dest=%0d data=%h",
                     name, exp_we, exp_dest_v, exp_data, res_we, res_dest, res_data);
            fails++;
        end else begin
            $display("ok %s dest=%0d data=%h", name, res_dest, res_data);
        end
    endtask

    task automatic check_exc(input string name, input lsu_pkg::excode_e exp_code,
                             input logic [lsu_pkg::data_w-1:0] exp_addr);
        checks++;
        if (!exc_valid) begin
            $display("%s returned a result where an exception was expected", name);
            fails++;
        end else if (exc_code !== exp_code || exc_badvaddr !== exp_addr) begin
            $display("MISMATCH %s expected %s addr=%h actual %s addr=%h",
                     name, exp_code.name(), exp_addr, exc_code.name(), exc_badvaddr);
            fails++;
        end else begin
            $display("ok %s %s addr=%h", name, exc_code.name(), exc_badvaddr);
        end
    endtask

    task automatic watch_results();
        int waited;
        for (int k = 0; k < exp_kind.size(); k++) begin
            waited = 0;
            @(negedge clk);
            while (!((res_valid || exc_valid) && res_allowin) && waited < 200) begin
                waited++;
                @(negedge clk);
            end
            if (!((res_valid || exc_valid) && res_allowin)) begin
                $display("no response for %s within 200 cycles", exp_name[k]);
                fails++;
                break;
            end
            if (exp_kind[k] == 4'h4 || exp_kind[k] == 4'h5) begin
                check_exc(exp_name[k], lsu_pkg::excode_e'({1'b0, exp_kind[k]}), exp_val[k]);
            end else begin
                check_result(exp_name[k], exp_kind[k] == 4'h0, exp_dest[k], exp_val[k]);
            end
        end
    endtask

    // anything left over is a duplicate or a result that should have been flushed
    task automatic expect_quiet();
        for (int c = 0; c < 30; c++) begin
            @(negedge clk);
            if (res_valid || exc_valid) begin
                $display("unexpected extra response after the last trace entry");
                fails++;
                break;
            end
        end
    endtask

    initial begin : backpressure
        logic [31:0] lfsr;
        logic [15:0] stall_mask;
        lfsr = 32'h8aa1abaf;
        forever begin
            for (int b = 0; b < 16; b++) begin
                stall_mask[b] = lfsr[0];
                lfsr = lfsr_step(lfsr);
            end
            for (int c = 0; c < 16; c++) begin
                @(posedge clk);
                #2;
                res_allowin = !stall_mask[c];
            end
        end
    end

    initial begin
        clk           = 1'b0;
        arst_n        = 1'b0;
        in_valid      = 1'b0;
        in_op         = lsu_pkg::op_none;
        in_addr       = '0;
        in_store_data = '0;
        in_rt_value   = '0;
        in_dest       = '0;
        res_allowin   = 1'b1;
        checks        = 0;
        fails         = 0;
        load_trace();
        if (fails == 0 && exp_kind.size() == 0) begin
            $display("the trace file holds no checked entries");
            fails++;
        end
        repeat (10) @(posedge clk);
        #2;
        arst_n = 1'b1;
        if (fails == 0) begin
            fork
                drive_trace();
                watch_results();
            join
            expect_quiet();
        end
        $display("%0d checks run, %0d failures", checks, fails);
        if (fails == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== dv/lsu_trace.txt ====
# op addr wdata rt dest kind expect, all hex, op is the mem_op_e code
# kind 0 writes result, 1 store result, 4 adel, 5 ades, f discarded by flush
8 00000100 80f17f01 00000000 01 1 00000100
1 00000100 00000000 00000000 02 0 80f17f01
8 00000104 cccccccc 00000000 03 1 00000104
9 00000104 12345678 00000000 04 1 00000104
1 00000104 00000000 00000000 05 0 cccc5678
9 00000106 dead9abc 00000000 06 1 00000106
1 00000104 00000000 00000000 07 0 9abc5678
a 00000104 123456a1 00000000 08 1 00000104
1 00000104 00000000 00000000 09 0 9abc56a1
a 00000105 000000b2 00000000 0a 1 00000105
1 00000104 00000000 00000000 0b 0 9abcb2a1
a 00000106 ffffffc3 00000000 0c 1 00000106
1 00000104 00000000 00000000 0d 0 9ac3b2a1
a 00000107 000000d4 00000000 0e 1 00000107
1 00000104 00000000 00000000 0f 0 d4c3b2a1
4 00000100 00000000 00000000 10 0 00000001
4 00000101 00000000 00000000 11 0 0000007f
4 00000102 00000000 00000000 12 0 fffffff1
4 00000103 00000000 00000000 13 0 ffffff80
5 00000100 00000000 00000000 14 0 00000001
5 00000101 00000000 00000000 15 0 0000007f
5 00000102 00000000 00000000 16 0 000000f1
5 00000103 00000000 00000000 17 0 00000080
2 00000100 00000000 00000000 18 0 00007f01
2 00000102 00000000 00000000 19 0 ffff80f1
3 00000100 00000000 00000000 1a 0 00007f01
3 00000102 00000000 00000000 1b 0 000080f1
6 00000100 00000000 55667788 1c 0 01667788
6 00000101 00000000 55667788 1d 0 7f017788
6 00000102 00000000 55667788 1e 0 f17f0188
6 00000103 00000000 55667788 1f 0 80f17f01
7 00000100 00000000 55667788 01 0 80f17f01
7 00000101 00000000 55667788 02 0 5580f17f
7 00000102 00000000 55667788 03 0 556680f1
7 00000103 00000000 55667788 04 0 55667780
0 00001234 00000000 00000000 05 0 00001234
1 00000101 00000000 00000000 06 4 00000101
a 00000100 000000ee 00000000 07 f 00000000
1 00000100 00000000 00000000 08 f 00000000
0 00000040 00000000 00000000 09 f 00000000
1 00000100 00000000 00000000 0a 0 80f17f01
2 00000103 00000000 00000000 0b 4 00000103
8 00000104 ffffffff 00000000 0c f 00000000
9 00000104 00000000 00000000 0d f 00000000
4 00000104 00000000 00000000 0e f 00000000
9 00000105 0000abcd 00000000 0f 5 00000105
a 00000107 00000000 00000000 10 f 00000000
8 00000104 00000000 00000000 11 f 00000000
0 00000080 00000000 00000000 12 f 00000000
1 00000104 00000000 00000000 13 0 d4c3b2a1

// ==== lsu.f ====
hw/lsu_pkg.sv
hw/lsu_stage_if.sv
hw/data_ram.sv
hw/mem_issue.sv
hw/mem_align.sv
hw/wb_commit.sv
hw/lsu_top.sv
dv/lsu_properties.sv
dv/lsu_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     := --timing --assert
TOP       := lsu_tb
FILELIST  := lsu.f
BUILD     := obj_dir
LOG       := sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	test $$status -eq 0 && ! grep -q "CHECKS FAILED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
